// File: Makefile
TOP = fl_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir

// File: src/fl_core.sv
`timescale 1ns/100ps

module fl_core (
	input  logic              clk,
	input  logic              rst,
	input  fl_pkg::fl_instr_t instr,
	output fl_pkg::fl_iaddr_t instr_addr,
	input  fl_pkg::fl_word_t  io_in,
	output fl_pkg::fl_port_t  addr_in,
	output logic              out_valid,
	output fl_pkg::fl_word_t  out_data,
	output fl_pkg::fl_port_t  addr_out,
	input  logic              credit_return,
	output logic              halted
);
	import fl_pkg::*;

	// Decode controls
	fl_alu_e   alu_op;
	fl_word_t  imm;
	fl_daddr_t daddr;
	logic      mem_we;
	logic      jump;
	logic      jump_if_zero;
	logic      call;
	logic      ret;
	logic      halt;
	fl_iaddr_t target;
	logic      out_req;
	fl_port_t  port;

	fl_word_t  acc;           // Execute to result
	logic      acc_zero;      // Execute to fetch
	logic      stall;         // Result to fetch and execute

	// Stages ----------------------------
	fl_fetch u_fetch (
		.clk, .rst, .stall, .acc_zero, .jump, .jump_if_zero,
		.call, .ret, .halt, .target, .instr_addr, .halted
	);

	fl_decode u_decode (
		.instr, .alu_op, .imm, .daddr, .mem_we, .jump, .jump_if_zero,
		.call, .ret, .halt, .target, .out_req, .port
	);

	fl_execute u_execute (
		.clk, .rst, .stall, .alu_op, .imm, .daddr, .mem_we,
		.io_in, .acc, .acc_zero
	);

	fl_result u_result (
		.clk, .rst, .out_req, .port, .acc, .credit_return,
		.stall, .out_valid, .out_data, .addr_out
	);

	assign addr_in = port;    // INN samples io_in in the same cycle

endmodule

// File: src/fl_decode.sv
`timescale 1ns/100ps

module fl_decode (
	input  fl_pkg::fl_instr_t instr,
	output fl_pkg::fl_alu_e   alu_op,
	output fl_pkg::fl_word_t  imm,
	output fl_pkg::fl_daddr_t daddr,
	output logic              mem_we,
	output logic              jump,
	output logic              jump_if_zero,
	output logic              call,
	output logic              ret,
	output logic              halt,
	output fl_pkg::fl_iaddr_t target,
	output logic              out_req,
	output fl_pkg::fl_port_t  port
);
	import fl_pkg::*;

	fl_opcode_t  opcode;
	fl_operand_t operand;
	fl_word_t    imm_ext;

	// Instruction fields ----------------
	assign opcode  = instr[OPCODE_W+OPERAND_W-1:OPERAND_W];
	assign operand = instr[OPERAND_W-1:0];
	assign imm_ext = {{(WORD_W-OPERAND_W){operand[OPERAND_W-1]}}, operand}; // Sign extend

	// The operand doubles as address, port and target
	assign daddr  = operand[DADDR_W-1:0];
	assign port   = operand[PORT_W-1:0];
	assign target = operand[IADDR_W-1:0];

	// Control per opcode ----------------
	always_comb begin
		// Shift left by zero leaves the accumulator as it is
		alu_op       = ALU_SHL;
		imm          = '0;
		mem_we       = 1'b0;
		jump         = 1'b0;
		jump_if_zero = 1'b0;
		call         = 1'b0;
		ret          = 1'b0;
		halt         = 1'b0;
		out_req      = 1'b0;
		case (opcode)
			LOD: alu_op = ALU_PMEM;
			LDI: begin
				alu_op = ALU_PIMM;
				imm    = imm_ext;
			end
			STO: mem_we = 1'b1;                 // Accumulator to memory
			ADD: alu_op = ALU_ADD;              // Memory operand
			SUB: alu_op = ALU_SUB;
			MLT: alu_op = ALU_MLT;
			AND: alu_op = ALU_AND;
			OR:  alu_op = ALU_OR;
			XOR: alu_op = ALU_XOR;
			NEG: alu_op = ALU_NEG;              // Accumulator only
			ABS: alu_op = ALU_ABS;
			SHL: begin
				alu_op = ALU_SHL;
				imm    = imm_ext;                   // Amount in the low bits
			end
			SHR: begin
				alu_op = ALU_SHR;
				imm    = imm_ext;
			end
			GRE: alu_op = ALU_GRE;
			EQU: alu_op = ALU_EQU;
			JMP: jump = 1'b1;
			JIZ: jump_if_zero = 1'b1;
			CAL: call = 1'b1;
			RET: ret = 1'b1;
			INN: alu_op = ALU_INN;              // Port number on addr_in
			OUT: out_req = 1'b1;
			HLT: halt = 1'b1;
			default: ;                          // NOP and unknown codes
		endcase
	end

endmodule

// File: src/fl_execute.sv
`timescale 1ns/100ps

module fl_execute (
	input  logic              clk,
	input  logic              rst,
	input  logic              stall,
	input  fl_pkg::fl_alu_e   alu_op,
	input  fl_pkg::fl_word_t  imm,
	input  fl_pkg::fl_daddr_t daddr,
	input  logic              mem_we,
	input  fl_pkg::fl_word_t  io_in,
	output fl_pkg::fl_word_t  acc,
	output logic              acc_zero
);
	import fl_pkg::*;

	fl_word_t   dmem [DMEM_DEPTH];   // Data memory
	fl_word_t   mem_rd;
	fl_word_t   alu_res;
	logic [4:0] shamt;

	// Data memory -----------------------
	assign mem_rd = dmem[daddr];     // Asynchronous read

	always_ff @(posedge clk) begin
		if (mem_we && !stall)
			dmem[daddr] <= acc;          // STO
	end

	assign shamt = imm[4:0];         // Up to 31, wide shifts clear the word

	// ALU -------------------------------
	always_comb begin
		case (alu_op)
			ALU_PMEM: alu_res = mem_rd;
			ALU_PIMM: alu_res = imm;
			ALU_ADD:  alu_res = acc + mem_rd;              // Wraps at 23 bits
			ALU_SUB:  alu_res = acc - mem_rd;
			ALU_MLT:  alu_res = acc * mem_rd;              // Low 23 bits of product
			ALU_AND:  alu_res = acc & mem_rd;
			ALU_OR:   alu_res = acc | mem_rd;
			ALU_XOR:  alu_res = acc ^ mem_rd;
			ALU_NEG:  alu_res = -acc;
			ALU_ABS:  alu_res = acc[WORD_W-1] ? -acc : acc; // Most negative stays put
			ALU_SHL:  alu_res = acc << shamt;
			ALU_SHR:  alu_res = fl_word_t'($unsigned(acc) >> shamt); // Logical, zero fill
			// Comparisons are signed
			ALU_GRE:  alu_res = {{(WORD_W-1){1'b0}}, (acc > mem_rd)};
			ALU_EQU:  alu_res = {{(WORD_W-1){1'b0}}, (acc == mem_rd)};
			ALU_INN:  alu_res = io_in;
			default:  alu_res = acc;
		endcase
	end

	// Accumulator -----------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			acc <= '0;
		else if (!stall)
			acc <= alu_res;              // Frozen during back-pressure
	end

	assign acc_zero = (acc == '0);   // For JIZ

endmodule

// File: src/fl_fetch.sv
`timescale 1ns/100ps

module fl_fetch (
	input  logic              clk,
	input  logic              rst,
	input  logic              stall,
	input  logic              acc_zero,
	input  logic              jump,
	input  logic              jump_if_zero,
	input  logic              call,
	input  logic              ret,
	input  logic              halt,
	input  fl_pkg::fl_iaddr_t target,
	output fl_pkg::fl_iaddr_t instr_addr,
	output logic              halted
);
	import fl_pkg::*;

	fl_fetch_e state;
	fl_iaddr_t pc;
	fl_iaddr_t pc_inc;
	fl_iaddr_t pc_next;
	fl_iaddr_t rstack [RSTACK_DEPTH];             // Return addresses
	logic [$clog2(RSTACK_DEPTH+1)-1:0] rsp;       // Entries in use, 0 to 4
	logic [$clog2(RSTACK_DEPTH+1)-1:0] rsp_dec;   // Pointer less one
	logic [$clog2(RSTACK_DEPTH)-1:0]   top;       // Newest entry
	logic [$clog2(RSTACK_DEPTH)-1:0]   wr_idx;    // Entry the next call fills
	logic      run;
	logic      take_jump;
	logic      stack_full;

	assign run        = !stall && (state == RUN); // Instruction may take effect
	assign pc_inc     = pc + 1'b1;
	assign take_jump  = jump || (jump_if_zero && acc_zero);
	assign stack_full = (rsp == RSTACK_DEPTH);
	assign rsp_dec    = rsp - 1'b1;
	assign top        = rsp_dec[$clog2(RSTACK_DEPTH)-1:0];
	assign wr_idx     = stack_full ? top : rsp[$clog2(RSTACK_DEPTH)-1:0];

	// Next address, priority order ------
	always_comb begin
		if (!run || halt)
			pc_next = pc;                                        // Hold on stall or halt
		else if (ret)
			pc_next = (rsp == '0) ? '0 : rstack[top];            // Empty stack returns to 0
		else if (call || take_jump)
			pc_next = target;
		else
			pc_next = pc_inc;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc    <= '0;
			rsp   <= '0;
			state <= RUN;
		end else begin
			pc <= pc_next;
			if (run) begin
				if (halt)
					state <= HALTED;                    // Stays here until reset
				else if (ret && rsp != '0)
					rsp <= rsp_dec;                     // Pop
				else if (call && !stack_full)
					rsp <= rsp + 1'b1;                  // Push, a full stack keeps its depth
			end
		end
	end

	// Stack storage, full stack overwrites the top entry
	always_ff @(posedge clk) begin
		if (run && call && !halt)
			rstack[wr_idx] <= pc_inc;
	end

	assign instr_addr = pc;
	assign halted     = (state == HALTED);

endmodule

// File: src/fl_pkg.sv
package fl_pkg;

	// Sizing ----------------------------
	localparam int WORD_W       = 23; // Data word, two's complement
	localparam int OPCODE_W     = 6;
	localparam int OPERAND_W    = 9;
	localparam int IADDR_W      = 9;  // Instruction ROM address
	localparam int DADDR_W      = 6;  // Data memory address
	localparam int PORT_W       = 3;  // 8 input and 8 output ports
	localparam int CREDIT_W     = 3;

	localparam int DMEM_DEPTH   = 64;
	localparam int RSTACK_DEPTH = 4;  // Return stack entries
	localparam int OUT_CREDITS  = 4;  // Credits held after reset

	// Types -----------------------------
	typedef logic signed [WORD_W-1:0]           fl_word_t;
	typedef logic [OPCODE_W-1:0]                fl_opcode_t;
	typedef logic [OPERAND_W-1:0]               fl_operand_t;
	typedef logic [OPCODE_W+OPERAND_W-1:0]      fl_instr_t;
	typedef logic [IADDR_W-1:0]                 fl_iaddr_t;
	typedef logic [DADDR_W-1:0]                 fl_daddr_t;
	typedef logic [PORT_W-1:0]                  fl_port_t;
	typedef logic [CREDIT_W-1:0]                fl_credit_t; // Holds 0 to OUT_CREDITS

	// Opcodes, upper 6 bits of the instruction
	typedef enum logic [OPCODE_W-1:0] {
		NOP = 6'd0,  LOD = 6'd1,  LDI = 6'd2,  STO = 6'd3,
		ADD = 6'd4,  SUB = 6'd5,  MLT = 6'd6,  AND = 6'd7,
		OR  = 6'd8,  XOR = 6'd9,  NEG = 6'd10, ABS = 6'd11,
		SHL = 6'd12, SHR = 6'd13, GRE = 6'd14, EQU = 6'd15,
		JMP = 6'd16, JIZ = 6'd17, CAL = 6'd18, RET = 6'd19,
		INN = 6'd20, OUT = 6'd21, HLT = 6'd22
	} fl_op_e;

	// ALU selector from decode to execute
	typedef enum logic [3:0] {
		ALU_PMEM,  // Load memory word
		ALU_PIMM,  // Load immediate
		ALU_ADD,
		ALU_SUB,
		ALU_MLT,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NEG,
		ALU_ABS,
		ALU_SHL,
		ALU_SHR,
		ALU_GRE,   // 1-bit result
		ALU_EQU,   // 1-bit result
		ALU_INN    // Input port word
	} fl_alu_e;

	typedef enum logic {RUN, HALTED} fl_fetch_e;

endpackage

// File: src/fl_result.sv
`timescale 1ns/100ps

module fl_result (
	input  logic             clk,
	input  logic             rst,
	input  logic             out_req,
	input  fl_pkg::fl_port_t port,
	input  fl_pkg::fl_word_t acc,
	input  logic             credit_return,
	output logic             stall,
	output logic             out_valid,
	output fl_pkg::fl_word_t out_data,
	output fl_pkg::fl_port_t addr_out
);
	import fl_pkg::*;

	fl_credit_t credits;      // Words the consumer can still take
	logic       no_credit;
	logic       send;

	// A credit returned this cycle can be spent at once
	assign no_credit = (credits == '0) && !credit_return;
	assign stall     = out_req && no_credit;
	assign send      = out_req && !no_credit;

	// Credit counter --------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			credits <= fl_credit_t'(OUT_CREDITS);
		else
			credits <= credits + fl_credit_t'(credit_return) - fl_credit_t'(send);
	end

	// One cycle pulse per word sent
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			out_valid <= 1'b0;
		else
			out_valid <= send;
	end

	// Payload held until the next word
	always_ff @(posedge clk) begin
		if (send) begin
			out_data <= acc;
			addr_out <= port;
		end
	end

endmodule

// File: verification/fl_asserts.sv
`timescale 1ns/100ps

module fl_asserts (
	input  logic               clk,
	input  logic               rst,
	input  logic               out_valid,
	input  logic               credit_return,
	input  fl_pkg::fl_credit_t credits
);
	import fl_pkg::*;

	// Credit protocol -------------------
	// Count is already spent when out_valid shows, so look one cycle back
	a_sent_with_credit: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> ($past(credits) != '0) || $past(credit_return))
		else $error("out_valid raised with no credit held");

	a_credit_max: assert property (@(posedge clk) disable iff (rst)
		credits <= fl_credit_t'(OUT_CREDITS))   // Consumer never over-returns
		else $error("credit count above OUT_CREDITS");

	// Reset behavior
	a_quiet_in_reset: assert property (@(posedge clk)
		rst |-> !out_valid)
		else $error("out_valid high during reset");

endmodule

// File: verification/fl_clock_gen.sv
`timescale 1ns/100ps

module fl_clock_gen (
	output logic clk
);

	// Free running clock, 4 ns period ---
	initial begin
		clk = 1'b0;
	end

	always #2 clk = ~clk;   // Half period

endmodule

// File: verification/fl_tb.sv
`timescale 1ns/100ps

module fl_tb;
	import fl_pkg::*;

	logic      clk;
	logic      rst;
	fl_instr_t instr;
	fl_iaddr_t instr_addr;
	fl_word_t  io_in;
	fl_port_t  addr_in;
	logic      out_valid;
	fl_word_t  out_data;
	fl_port_t  addr_out;
	logic      credit_return;
	logic      halted;

	fl_instr_t  rom [512];        // Instruction ROM model
	fl_iaddr_t  prog_len;         // Next free ROM slot
	int         errors;
	logic       hold_credits;     // Consumer keeps credits back
	logic [1:0] ret_dly;          // Two cycle return delay
	int         owed;             // Credits waiting to go back
	fl_word_t   got_words [$];
	fl_port_t   got_ports [$];
	fl_word_t   exp_words [$];
	fl_port_t   exp_ports [$];

	fl_clock_gen u_clk (.clk(clk));

	fl_core u_dut (
		.clk, .rst, .instr, .instr_addr, .io_in, .addr_in,
		.out_valid, .out_data, .addr_out, .credit_return, .halted
	);

	bind fl_result fl_asserts u_asserts (
		.clk(clk), .rst(rst), .out_valid(out_valid),
		.credit_return(credit_return), .credits(credits)
	);

	// Models ----------------------------
	assign instr = rom[instr_addr];                            // Answers in the same cycle
	assign io_in = fl_word_t'(1000 + 7 * int'(addr_in));        // Fixed input port rule

	always @(negedge clk) begin
		if (out_valid) begin                                   // Middle of the pulse
			got_words.push_back(out_data);
			got_ports.push_back(addr_out);
		end
	end

	// One credit back per word, two cycles after it arrives
	always @(posedge clk or posedge rst) begin
		int owed_now;
		if (rst) begin
			ret_dly       <= '0;
			owed          <= 0;
			credit_return <= 1'b0;
		end else begin
			owed_now = owed + int'(ret_dly[1]);
			ret_dly <= {ret_dly[0], out_valid};
			if (owed_now > 0 && !hold_credits) begin
				credit_return <= 1'b1;
				owed_now      = owed_now - 1;
			end else
				credit_return <= 1'b0;
			owed <= owed_now;
		end
	end

	// Program and expectation helpers ---
	task automatic put(fl_op_e op, int operand);
		rom[prog_len] = {op, fl_operand_t'(operand)};
		prog_len++;
	endtask

	// Load a memory word, apply one operation and send the result
	task automatic put_alu_out(int src, fl_op_e op, int operand, int port);
		put(LOD, src);
		put(op, operand);
		put(OUT, port);
	endtask

	task automatic at(fl_iaddr_t addr);
		prog_len = addr;                                       // Place following code here
	endtask

	task automatic expect_out(int word, int port);
		exp_words.push_back(fl_word_t'(word));                 // Keep low 23 bits
		exp_ports.push_back(fl_port_t'(port));
	endtask

	task automatic start_test();
		int i;
		@(posedge clk);
		rst <= 1'b1;
		@(negedge clk);                                        // Core in reset before ROM changes
		for (i = 0; i < 512; i++)
			rom[fl_iaddr_t'(i)] = {HLT, fl_operand_t'(i)};     // Stray fetches halt
		prog_len = '0;
		got_words.delete();
		got_ports.delete();
		exp_words.delete();
		exp_ports.delete();
	endtask

	task automatic release_reset();
		repeat (16) @(posedge clk);
		rst <= 1'b0;
	endtask

	task automatic wait_halted(string name, int limit);
		int n;
		n = 0;
		while (!halted && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (!halted) begin
			errors++;
			$display("Timeout in %s: the core did not halt within %0d cycles", name, limit);
		end
	endtask

	task automatic wait_words(string name, int count, int limit);
		int n;
		n = 0;
		while (got_words.size() < count && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (got_words.size() < count) begin
			errors++;
			$display("Timeout in %s: only %0d of %0d words arrived", name,
				got_words.size(), count);
		end
	endtask

	// Compare tasks ---------------------
	task automatic check_word(string name, fl_word_t exp, fl_word_t act);
		if (act !== exp) begin
			errors++;
			$display("Error %s: expected word %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_port(string name, fl_port_t exp, fl_port_t act);
		if (act !== exp) begin
			errors++;
			$display("Error %s: expected port %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_iaddr(string name, fl_iaddr_t exp, fl_iaddr_t act);
		if (act !== exp) begin
			errors++;
			$display("Error %s: expected address %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_outputs(string name);
		int i;
		if (got_words.size() != exp_words.size()) begin
			errors++;
			$display("%s: %0d output words expected but %0d received", name,
				exp_words.size(), got_words.size());
		end
		for (i = 0; i < exp_words.size() && i < got_words.size(); i++) begin
			check_word(name, exp_words[i], got_words[i]);
			check_port(name, exp_ports[i], got_ports[i]);
		end
	endtask

	// Tests -----------------------------
	task automatic test_alu();
		int a;
		int b;
		int sq;
		a  = 200;
		b  = -75;
		sq = 255 * 255;
		start_test();
		put(LDI, b);
		put(STO, 1);                                   // mem[1] = b
		put(LDI, a);
		put(STO, 0);                                   // mem[0] = a
		put(LDI, 255);
		put(STO, 2);
		put_alu_out(0, ADD, 1, 0);
		expect_out(a + b, 0);
		put_alu_out(0, SUB, 1, 1);
		expect_out(a - b, 1);
		put_alu_out(0, MLT, 1, 2);
		expect_out(a * b, 2);
		put_alu_out(0, AND, 1, 3);
		expect_out(a & b, 3);
		put_alu_out(0, OR, 1, 4);
		expect_out(a | b, 4);
		put_alu_out(0, XOR, 1, 5);
		expect_out(a ^ b, 5);
		put_alu_out(0, GRE, 1, 6);
		expect_out((a > b) ? 1 : 0, 6);
		put_alu_out(1, GRE, 0, 7);
		expect_out((b > a) ? 1 : 0, 7);
		put_alu_out(0, EQU, 0, 0);
		expect_out(1, 0);
		put_alu_out(0, NEG, 0, 1);
		expect_out(-a, 1);
		put_alu_out(1, ABS, 0, 2);
		expect_out((b < 0) ? -b : b, 2);
		put_alu_out(1, SHL, 5, 3);
		expect_out(b << 5, 3);
		put_alu_out(1, SHR, 3, 4);
		expect_out((b & 'h7FFFFF) >> 3, 4);
		// Square of 255 squared again, far past 23 bits
		put(LOD, 2);
		put(MLT, 2);
		put(STO, 3);
		put(MLT, 3);
		put(OUT, 5);
		expect_out(sq * sq, 5);
		put_alu_out(0, EQU, 1, 6);                     // Unequal words
		expect_out((a == b) ? 1 : 0, 6);
		put_alu_out(0, ABS, 0, 7);                     // Positive word
		expect_out((a < 0) ? -a : a, 7);
		put(HLT, 0);
		release_reset();
		wait_halted("alu", 500);
		check_outputs("alu");
	endtask

	task automatic test_control();
		int i;
		start_test();
		put(LDI, 1);
		put(STO, 1);                                   // Constant one
		put(LDI, 5);                                   // Counter lives in acc
		put(JIZ, 7);                                   // Loop top at 3
		put(OUT, 2);
		put(SUB, 1);
		put(JMP, 3);
		put(LDI, 10);
		put(CAL, 20);
		put(OUT, 3);
		put(LDI, 40);
		put(CAL, 20);
		put(OUT, 4);
		put(HLT, 0);
		at(20);                                        // Subroutine doubles acc
		put(STO, 2);
		put(ADD, 2);
		put(OUT, 5);
		put(RET, 0);
		for (i = 5; i > 0; i--)
			expect_out(i, 2);
		expect_out(10 * 2, 5);
		expect_out(10 * 2, 3);
		expect_out(40 * 2, 5);
		expect_out(40 * 2, 4);
		release_reset();
		wait_halted("control", 500);
		check_outputs("control");
	endtask

	task automatic test_input_port();
		int p;
		start_test();
		for (p = 0; p < 8; p++) begin
			put(INN, p);
			put(OUT, p);
			expect_out(1000 + 7 * p, p);
		end
		put(HLT, 0);
		release_reset();
		wait_halted("input_port", 500);
		check_outputs("input_port");
	endtask

	task automatic test_backpressure();
		int i;
		start_test();
		hold_credits <= 1'b1;
		for (i = 0; i < 8; i++) begin
			put(LDI, i + 1);
			put(OUT, i);
			expect_out(i + 1, i);
		end
		put(HLT, 0);
		release_reset();
		wait_words("backpressure", 4, 200);
		repeat (20) @(negedge clk);                    // Quiet window, no fifth word
		if (got_words.size() != 4) begin
			errors++;
			$display("backpressure: %0d words arrived with credits held, 4 allowed",
				got_words.size());
		end
		if (halted) begin
			errors++;
			$display("backpressure: core halted while it should be stalled");
		end
		check_iaddr("backpressure", 9, instr_addr);    // Fifth OUT holds the PC
		@(posedge clk);
		hold_credits <= 1'b0;
		wait_halted("backpressure", 500);
		check_outputs("backpressure");
	endtask

	task automatic test_random();
		int i;
		int x;
		int y;
		start_test();
		for (i = 0; i < 10; i++) begin
			x = int'($urandom % 512) - 256;            // Signed 9-bit immediates
			y = int'($urandom % 512) - 256;
			put(LDI, y);
			put(STO, 1);
			put(LDI, x);
			put(ADD, 1);
			put(OUT, 0);
			put(LDI, x);
			put(MLT, 1);
			put(OUT, 1);
			expect_out(x + y, 0);
			expect_out(x * y, 1);
		end
		put(HLT, 0);
		release_reset();
		wait_halted("random", 1000);
		check_outputs("random");
	endtask

	// Sequence --------------------------
	initial begin
		rst           = 1'b1;
		credit_return <= 1'b0;
		errors        = 0;
		hold_credits  = 1'b0;
		prog_len      = '0;
		void'($urandom(79));
		test_alu();
		test_control();
		test_input_port();
		test_backpressure();
		test_random();
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: verilog.f
src/fl_pkg.sv
src/fl_fetch.sv
src/fl_decode.sv
src/fl_execute.sv
src/fl_result.sv
src/fl_core.sv
verification/fl_clock_gen.sv
verification/fl_asserts.sv
verification/fl_tb.sv
